//--- Makefile
TOP = scalar_core_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f scalar_core.f --top-module scalar_core
	verilator --lint-only --timing -f scalar_core.f --top-module $(TOP)

sim:
	verilator --binary --timing -f scalar_core.f --top-module $(TOP)
	@out="$$(obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

//--- scalar_core.f
+incdir+source
source/scalar_isa_pkg.sv
source/scalar_pipe_pkg.sv
source/instr_mem.sv
source/program_counter.sv
source/operand_read.sv
source/exec_unit.sv
source/scalar_core.sv
test/scalar_core_tb.sv

//--- source/exec_unit.sv
/* Execute stage: ALU, condition register, write-back, redirect,
   halt, result register and result port credit counter */
`timescale 1ns/1ps
`include "scalar_core_macros.svh"

module exec_unit (
	input  logic                          clock,
	input  logic                          reset,
	input  scalar_pipe_pkg::exec_entry_t  exec_entry,
	input  logic                          credit_return,
	output logic                          wb_enable,
	output scalar_isa_pkg::reg_idx_t      wb_index,
	output scalar_pipe_pkg::data_t        wb_data,
	output scalar_pipe_pkg::redirect_t    redirect,
	output logic                          halt,
	output logic                          stall,
	output scalar_pipe_pkg::result_t      result
);
	import scalar_isa_pkg::*;
	import scalar_pipe_pkg::*;

	localparam int CREDIT_WIDTH = $clog2(`OUT_CREDITS + 1);
	localparam int SHIFT_WIDTH = $clog2(`DATA_WIDTH);

	opcode_t                 opcode;
	data_t                   op_a;
	data_t                   op_b;
	data_t                   alu_out;
	logic                    writes_reg;
	logic                    condition;
	logic                    out_fire;
	logic [CREDIT_WIDTH-1:0] credits;
	logic                    result_valid;
	data_t                   result_data;

	assign opcode = exec_entry.instr.opcode;
	assign op_a = exec_entry.op_a;
	assign op_b = exec_entry.op_b;

	////////////////////////////////////////////////////////////
	// ALU and write-back
	////////////////////////////////////////////////////////////

	always_comb begin
		alu_out = '0;
		writes_reg = 1'b1;
		case (opcode)
			ADD, ADDI: alu_out = op_a + op_b;
			SUB:       alu_out = op_a - op_b;
			AND:       alu_out = op_a & op_b;
			OR:        alu_out = op_a | op_b;
			XOR:       alu_out = op_a ^ op_b;
			SHL:       alu_out = op_a << op_b[SHIFT_WIDTH-1:0];
			SHR:       alu_out = op_a >> op_b[SHIFT_WIDTH-1:0];
			default:   writes_reg = 1'b0;
		endcase
	end

	assign wb_enable = exec_entry.valid && writes_reg;
	assign wb_index = exec_entry.instr.dst;
	assign wb_data = alu_out;

	// Compares only set the flag, BRANCH reads it the next cycle
	always_ff @(posedge clock) begin
		if (reset) begin
			condition <= 1'b0;
		end else if (exec_entry.valid && opcode == CMPLT) begin
			condition <= op_a < op_b;
		end else if (exec_entry.valid && opcode == CMPEQ) begin
			condition <= op_a == op_b;
		end
	end

	assign redirect.taken = exec_entry.valid
		&& (opcode == JUMP || (opcode == BRANCH && condition));
	assign redirect.target = addr_t'(exec_entry.instr.immediate);
	assign halt = exec_entry.valid && opcode == HALT;

	////////////////////////////////////////////////////////////
	// Result port
	////////////////////////////////////////////////////////////

	// OUT waits here until a credit is available
	assign stall = exec_entry.valid && opcode == OUT && credits == '0;
	assign out_fire = exec_entry.valid && opcode == OUT && credits != '0;

	always_ff @(posedge clock) begin
		if (reset) begin
			credits <= CREDIT_WIDTH'(`OUT_CREDITS);
		end else begin
			credits <= credits + CREDIT_WIDTH'(credit_return) - CREDIT_WIDTH'(out_fire);
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			result_valid <= 1'b0;
		end else begin
			result_valid <= out_fire;
		end
	end

	always_ff @(posedge clock) begin
		if (out_fire) begin
			result_data <= op_a;
		end
	end

	assign result = '{valid: result_valid, data: result_data};

endmodule

//--- source/instr_mem.sv
/* Instruction memory with host store port and registered fetch read */
`timescale 1ns/1ps
`include "scalar_core_macros.svh"

module instr_mem (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    store_valid,
	input  scalar_isa_pkg::addr_t   store_address,
	input  scalar_isa_pkg::instr_t  store_instr,
	input  logic                    fetch_valid,
	input  scalar_isa_pkg::addr_t   fetch_address,
	output scalar_isa_pkg::instr_t  fetch_instr,
	output logic                    fetch_instr_valid
);
	import scalar_isa_pkg::*;

	instr_t mem [`IMEM_DEPTH];

	// Host writes only while the core is stopped
	always_ff @(posedge clock) begin
		if (store_valid) begin
			mem[store_address] <= store_instr;
		end
	end

	always_ff @(posedge clock) begin
		if (fetch_valid) begin
			fetch_instr <= mem[fetch_address];
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			fetch_instr_valid <= 1'b0;
		end else begin
			fetch_instr_valid <= fetch_valid;
		end
	end

endmodule

//--- source/operand_read.sv
/* Read stage: register file, operand select with execute bypass,
   and the read-to-execute pipeline register */
`timescale 1ns/1ps
`include "scalar_core_macros.svh"

module operand_read (
	input  logic                          clock,
	input  logic                          reset,
	input  scalar_isa_pkg::instr_t        fetch_instr,
	input  logic                          fetch_instr_valid,
	input  logic                          stall,
	input  logic                          flush,
	input  logic                          wb_enable,
	input  scalar_isa_pkg::reg_idx_t      wb_index,
	input  scalar_pipe_pkg::data_t        wb_data,
	output scalar_pipe_pkg::exec_entry_t  exec_entry
);
	import scalar_isa_pkg::*;
	import scalar_pipe_pkg::*;

	data_t  regs [`REG_COUNT];
	data_t  src1_data;
	data_t  src2_data;
	data_t  op_b_next;
	logic   entry_valid;
	instr_t entry_instr;
	data_t  entry_op_a;
	data_t  entry_op_b;

	// Write-back of this cycle is not in the array yet
	function automatic data_t read_reg(input reg_idx_t index);
		if (wb_enable && wb_index == index) begin
			return wb_data;
		end
		return regs[index];
	endfunction

	always_ff @(posedge clock) begin
		if (wb_enable) begin
			regs[wb_index] <= wb_data;
		end
	end

	always_comb begin
		src1_data = read_reg(fetch_instr.src1);
		src2_data = read_reg(fetch_instr.src2);
		// ADDI zero-extends its immediate
		op_b_next = (fetch_instr.opcode == ADDI) ? data_t'(fetch_instr.immediate) : src2_data;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			entry_valid <= 1'b0;
		end else if (flush) begin
			entry_valid <= 1'b0;
		end else if (!stall) begin
			entry_valid <= fetch_instr_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (!stall) begin
			entry_instr <= fetch_instr;
			entry_op_a <= src1_data;
			entry_op_b <= op_b_next;
		end
	end

	assign exec_entry = '{valid: entry_valid, instr: entry_instr,
		op_a: entry_op_a, op_b: entry_op_b};

endmodule

//--- source/program_counter.sv
/* Program address control: core state FSM, PC increment,
   redirect, stall hold and fetch request */
`timescale 1ns/1ps

module program_counter (
	input  logic                         clock,
	input  logic                         reset,
	input  logic                         run,
	input  logic                         stall,
	input  scalar_pipe_pkg::redirect_t   redirect,
	input  logic                         halt,
	output logic                         fetch_valid,
	output scalar_isa_pkg::addr_t        fetch_address,
	output scalar_pipe_pkg::core_state_t state
);
	import scalar_isa_pkg::*;
	import scalar_pipe_pkg::*;

	// Address of the next fetch
	addr_t pc;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= IDLE;
			pc <= '0;
		end else begin
			case (state)
				IDLE, HALTED: begin
					if (run) begin
						state <= RUN;
						pc <= '0;
					end
				end
				RUN: begin
					if (halt) begin
						state <= HALTED;
					end else if (redirect.taken) begin
						pc <= redirect.target;
					end else if (!stall) begin
						pc <= pc + addr_t'(1);
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// No fetch in the redirect or halt cycle, the slot would be squashed
	assign fetch_valid = (state == RUN) && !redirect.taken && !halt;

	// On stall re-read the word now in the read stage so it is kept
	assign fetch_address = stall ? pc - addr_t'(1) : pc;

endmodule

//--- source/scalar_core.sv
/* Scalar core top: fetch, operand read and execute stages */
`timescale 1ns/1ps

module scalar_core (
	input  logic                         clock,
	input  logic                         reset,
	input  logic                         store_valid,
	input  scalar_isa_pkg::addr_t        store_address,
	input  scalar_isa_pkg::instr_t       store_instr,
	input  logic                         run,
	output scalar_pipe_pkg::result_t     result,
	input  logic                         credit_return,
	output scalar_pipe_pkg::core_state_t state
);
	import scalar_isa_pkg::*;
	import scalar_pipe_pkg::*;

	logic        fetch_valid;
	addr_t       fetch_address;
	instr_t      fetch_instr;
	logic        fetch_instr_valid;
	exec_entry_t exec_entry;
	logic        wb_enable;
	reg_idx_t    wb_index;
	data_t       wb_data;
	redirect_t   redirect;
	logic        halt;
	logic        stall;
	logic        flush;

	// Taken jump or HALT kills the instruction in the read stage
	assign flush = redirect.taken || halt;

	////////////////////////////////////////////////////////////
	// Fetch
	////////////////////////////////////////////////////////////

	program_counter pc_ctrl (
		.clock         (clock),
		.reset         (reset),
		.run           (run),
		.stall         (stall),
		.redirect      (redirect),
		.halt          (halt),
		.fetch_valid   (fetch_valid),
		.fetch_address (fetch_address),
		.state         (state)
	);

	instr_mem imem (
		.clock             (clock),
		.reset             (reset),
		.store_valid       (store_valid),
		.store_address     (store_address),
		.store_instr       (store_instr),
		.fetch_valid       (fetch_valid),
		.fetch_address     (fetch_address),
		.fetch_instr       (fetch_instr),
		.fetch_instr_valid (fetch_instr_valid)
	);

	////////////////////////////////////////////////////////////
	// Read and execute
	////////////////////////////////////////////////////////////

	operand_read read_stage (
		.clock             (clock),
		.reset             (reset),
		.fetch_instr       (fetch_instr),
		.fetch_instr_valid (fetch_instr_valid),
		.stall             (stall),
		.flush             (flush),
		.wb_enable         (wb_enable),
		.wb_index          (wb_index),
		.wb_data           (wb_data),
		.exec_entry        (exec_entry)
	);

	exec_unit exec_stage (
		.clock         (clock),
		.reset         (reset),
		.exec_entry    (exec_entry),
		.credit_return (credit_return),
		.wb_enable     (wb_enable),
		.wb_index      (wb_index),
		.wb_data       (wb_data),
		.redirect      (redirect),
		.halt          (halt),
		.stall         (stall),
		.result        (result)
	);

endmodule

//--- source/scalar_core_macros.svh
/* Sizing macros for the scalar core: data and instruction widths,
   register count, instruction memory depth and result port credits */
`ifndef SCALAR_CORE_MACROS_SVH
`define SCALAR_CORE_MACROS_SVH

// Datapath
`define DATA_WIDTH      32
`define REG_COUNT       8
`define REG_IDX_WIDTH   ($clog2(`REG_COUNT))

// Instruction word and memory
`define INSTR_WIDTH     32
`define OPCODE_WIDTH    4
`define IMM_WIDTH       16
`define IMEM_DEPTH      64
`define IMEM_ADDR_WIDTH ($clog2(`IMEM_DEPTH))

// Result port credits held after reset
`define OUT_CREDITS     4

`endif

//--- source/scalar_isa_pkg.sv
/* Instruction set package: opcode enum, instruction word struct,
   register index and instruction address types */
`include "scalar_core_macros.svh"

package scalar_isa_pkg;

	typedef logic [`REG_IDX_WIDTH-1:0] reg_idx_t;
	typedef logic [`IMEM_ADDR_WIDTH-1:0] addr_t;

	// Shifts use the low bits of src2, CMPLT is unsigned
	typedef enum logic [`OPCODE_WIDTH-1:0] {
		NOP    = 4'h0,
		ADD    = 4'h1,
		SUB    = 4'h2,
		AND    = 4'h3,
		OR     = 4'h4,
		XOR    = 4'h5,
		SHL    = 4'h6,
		SHR    = 4'h7,
		ADDI   = 4'h8,
		CMPLT  = 4'h9,
		CMPEQ  = 4'ha,
		JUMP   = 4'hb,
		BRANCH = 4'hc,
		OUT    = 4'hd,
		HALT   = 4'he
	} opcode_t;

	// Unused bits between the register fields and the immediate
	localparam int SPARE_WIDTH = `INSTR_WIDTH - `OPCODE_WIDTH - 3 * `REG_IDX_WIDTH - `IMM_WIDTH;

	typedef struct packed {
		opcode_t                 opcode;
		reg_idx_t                dst;
		reg_idx_t                src1;
		reg_idx_t                src2;
		logic [SPARE_WIDTH-1:0]  spare;
		logic [`IMM_WIDTH-1:0]   immediate;
	} instr_t;

endpackage

//--- source/scalar_pipe_pkg.sv
/* Pipeline package: core state enum, read-to-execute entry,
   result beat and branch redirect structs */
`include "scalar_core_macros.svh"

package scalar_pipe_pkg;

	typedef logic [`DATA_WIDTH-1:0] data_t;

	typedef enum logic [1:0] {
		IDLE   = 2'd0,
		RUN    = 2'd1,
		HALTED = 2'd2
	} core_state_t;

	// Read stage output, consumed by execute
	typedef struct packed {
		logic                    valid;
		scalar_isa_pkg::instr_t  instr;
		data_t                   op_a;
		data_t                   op_b;
	} exec_entry_t;

	// One beat on the result port
	typedef struct packed {
		logic   valid;
		data_t  data;
	} result_t;

	typedef struct packed {
		logic                   taken;
		scalar_isa_pkg::addr_t  target;
	} redirect_t;

endpackage

//--- test/scalar_core_tb.sv
/* Scalar core testbench: program images, reference model, result monitor,
   randomized credit return and cycle timeout */
`timescale 1ns/1ps
`include "scalar_core_macros.svh"

module scalar_core_tb;
	import scalar_isa_pkg::*;
	import scalar_pipe_pkg::*;

	localparam int PROGRAM_COUNT = 2;
	localparam int REF_STEP_LIMIT = 1000;

	logic        clock;
	logic        reset;
	logic        store_valid;
	addr_t       store_address;
	instr_t      store_instr;
	logic        run;
	result_t     result;
	logic        credit_return;
	core_state_t state;

	instr_t      programs [PROGRAM_COUNT][`IMEM_DEPTH];
	int          prog_len [PROGRAM_COUNT];
	int          prog_out_count [PROGRAM_COUNT];
	data_t       expected_q [$];
	int          release_q [$];
	int          received = 0;
	int          allowed_count = 0;
	int          outstanding = 0;
	int          cycle_count = 0;
	int          timeout_limit = 0;
	logic [31:0] lfsr_state = 32'ha57965ba;

	scalar_core UUT (
		.clock         (clock),
		.reset         (reset),
		.store_valid   (store_valid),
		.store_address (store_address),
		.store_instr   (store_instr),
		.run           (run),
		.result        (result),
		.credit_return (credit_return),
		.state         (state)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("TESTS FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			abort_run($sformatf("Error at %0d ns: %s expected %h, got %h",
				$time, what, expected, actual));
		end
	endtask

	// Galois LFSR step with taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] value);
		return value[0] ? ((value >> 1) ^ 32'h80200003) : (value >> 1);
	endfunction

	function automatic int take_bits(input int count);
		int value;
		value = 0;
		for (int n = 0; n < count; n++) begin
			value = (value << 1) | int'(lfsr_state[0]);
			lfsr_state = lfsr_step(lfsr_state);
		end
		return value;
	endfunction

	function automatic instr_t encode(input opcode_t op, input int dst, input int src1,
		input int src2, input int imm);
		instr_t word;
		word.opcode = op;
		word.dst = reg_idx_t'(dst);
		word.src1 = reg_idx_t'(src1);
		word.src2 = reg_idx_t'(src2);
		word.spare = '0;
		word.immediate = 16'(imm);
		return word;
	endfunction

	task automatic add_instr(input int p, input opcode_t op, input int dst, input int src1,
		input int src2, input int imm);
		programs[p][prog_len[p]] = encode(op, dst, src1, src2, imm);
		prog_len[p]++;
	endtask

	////////////////////////////////////////////////////////////
	// Programs
	////////////////////////////////////////////////////////////

	task automatic build_programs();
		// Dependent ALU chain with every result sent out
		add_instr(0, XOR, 0, 0, 0, 0);
		add_instr(0, ADDI, 1, 0, 0, 'h1234);
		add_instr(0, OUT, 0, 1, 0, 0);
		add_instr(0, ADDI, 2, 1, 0, 'h0f0f);
		add_instr(0, OUT, 0, 2, 0, 0);
		add_instr(0, ADD, 3, 2, 1, 0);
		add_instr(0, OUT, 0, 3, 0, 0);
		add_instr(0, SUB, 4, 1, 3, 0);
		add_instr(0, OUT, 0, 4, 0, 0);
		add_instr(0, AND, 5, 4, 3, 0);
		add_instr(0, OUT, 0, 5, 0, 0);
		add_instr(0, OR, 6, 5, 2, 0);
		add_instr(0, OUT, 0, 6, 0, 0);
		add_instr(0, XOR, 7, 6, 4, 0);
		add_instr(0, OUT, 0, 7, 0, 0);
		add_instr(0, ADDI, 1, 0, 0, 5);
		add_instr(0, SHL, 2, 7, 1, 0);
		add_instr(0, OUT, 0, 2, 0, 0);
		add_instr(0, SHR, 3, 4, 1, 0);
		add_instr(0, OUT, 0, 3, 0, 0);
		// Counting loop from 0 to 5 with its body at address 23
		add_instr(0, ADDI, 1, 0, 0, 0);
		add_instr(0, ADDI, 2, 0, 0, 6);
		add_instr(0, ADDI, 3, 0, 0, 1);
		add_instr(0, OUT, 0, 1, 0, 0);
		add_instr(0, ADD, 1, 1, 3, 0);
		add_instr(0, CMPLT, 0, 1, 2, 0);
		add_instr(0, BRANCH, 0, 0, 0, 23);
		add_instr(0, JUMP, 0, 0, 0, 30);
		add_instr(0, OUT, 0, 2, 0, 0);
		add_instr(0, OUT, 0, 3, 0, 0);
		// Burst longer than the credit pool
		for (int r = 1; r < `REG_COUNT; r++) begin
			add_instr(0, OUT, 0, r, 0, 0);
		end
		add_instr(0, HALT, 0, 0, 0, 0);
		add_instr(0, OUT, 0, 1, 0, 0);

		// Second image run after the first one halts
		add_instr(1, XOR, 0, 0, 0, 0);
		add_instr(1, ADDI, 1, 0, 0, 'hbeef);
		add_instr(1, ADDI, 2, 0, 0, 3);
		add_instr(1, CMPEQ, 0, 2, 2, 0);
		add_instr(1, BRANCH, 0, 0, 0, 7);
		add_instr(1, OUT, 0, 2, 0, 0);
		add_instr(1, HALT, 0, 0, 0, 0);
		add_instr(1, SHL, 3, 1, 2, 0);
		add_instr(1, OUT, 0, 3, 0, 0);
		add_instr(1, SUB, 4, 3, 1, 0);
		add_instr(1, OUT, 0, 4, 0, 0);
		add_instr(1, CMPLT, 0, 4, 1, 0);
		add_instr(1, HALT, 0, 0, 0, 0);
		add_instr(1, OUT, 0, 1, 0, 0);
	endtask

	// Instruction-level model that appends OUT values and returns the step count
	function automatic int run_reference(input int p);
		data_t  regs [`REG_COUNT];
		logic   condition;
		instr_t ins;
		data_t  a;
		data_t  b;
		int     pc;
		int     steps;
		logic   done;
		condition = 1'b0;
		pc = 0;
		steps = 0;
		done = 1'b0;
		foreach (regs[i]) regs[i] = '0;
		while (!done && steps < REF_STEP_LIMIT) begin
			ins = programs[p][pc];
			a = regs[ins.src1];
			b = (ins.opcode == ADDI) ? data_t'(ins.immediate) : regs[ins.src2];
			pc++;
			steps++;
			case (ins.opcode)
				ADD, ADDI: regs[ins.dst] = a + b;
				SUB:       regs[ins.dst] = a - b;
				AND:       regs[ins.dst] = a & b;
				OR:        regs[ins.dst] = a | b;
				XOR:       regs[ins.dst] = a ^ b;
				SHL:       regs[ins.dst] = a << b[4:0];
				SHR:       regs[ins.dst] = a >> b[4:0];
				CMPLT:     condition = a < b;
				CMPEQ:     condition = a == b;
				JUMP:      pc = int'(ins.immediate);
				BRANCH:    if (condition) pc = int'(ins.immediate);
				OUT:       expected_q.push_back(a);
				HALT:      done = 1'b1;
				default:   ;
			endcase
		end
		return steps;
	endfunction

	////////////////////////////////////////////////////////////
	// Stimulus and checking processes
	////////////////////////////////////////////////////////////

	task automatic load_and_start(input int p);
		for (int n = 0; n < prog_len[p]; n++) begin
			@(posedge clock);
			store_valid <= 1'b1;
			store_address <= addr_t'(n);
			store_instr <= programs[p][n];
		end
		allowed_count = prog_out_count[p];
		@(posedge clock);
		store_valid <= 1'b0;
		run <= 1'b1;
		@(posedge clock);
		run <= 1'b0;
		@(negedge clock);
		check_value("state after run", 32'(RUN), 32'(state));
	endtask

	task automatic wait_for_halt(input int p);
		@(negedge clock);
		while (state != HALTED || received < prog_out_count[p] || release_q.size() != 0) begin
			@(negedge clock);
		end
		// Quiet period so a late beat would still be caught
		repeat (8) @(negedge clock);
		check_value("state after HALT", 32'(HALTED), 32'(state));
	endtask

	// Cycle count, timeout and credit release
	initial begin
		credit_return <= 1'b0;
		forever begin
			@(posedge clock);
			cycle_count++;
			if (cycle_count > timeout_limit) begin
				abort_run($sformatf("Timeout: run did not finish within %0d cycles",
					timeout_limit));
			end
			if (release_q.size() != 0 && release_q[0] <= cycle_count) begin
				credit_return <= 1'b1;
				void'(release_q.pop_front());
				outstanding--;
			end else begin
				credit_return <= 1'b0;
			end
		end
	end

	// Result monitor sampling on the falling edge
	initial begin
		forever begin
			@(negedge clock);
			if (result.valid === 1'b1) begin
				if (received >= allowed_count) begin
					abort_run("A result beat appeared with no OUT left to run");
				end
				check_value("result beat", expected_q[received], result.data);
				received++;
				outstanding++;
				if (outstanding > `OUT_CREDITS) begin
					abort_run("More result beats outstanding than credits");
				end
				release_q.push_back(cycle_count + take_bits(3));
			end
		end
	end

	initial begin
		int steps;
		int total_steps;
		reset <= 1'b1;
		store_valid <= 1'b0;
		store_address <= '0;
		store_instr <= '0;
		run <= 1'b0;
		total_steps = 0;
		build_programs();
		for (int p = 0; p < PROGRAM_COUNT; p++) begin
			steps = run_reference(p);
			if (steps >= REF_STEP_LIMIT) begin
				abort_run("Reference model found no HALT in a program");
			end
			total_steps += steps;
			prog_out_count[p] = expected_q.size();
		end
		timeout_limit = total_steps * 20 + 200;

		repeat (2) @(posedge clock);
		reset <= 1'b0;

		// Idle core stays quiet until run
		repeat (10) @(negedge clock);
		check_value("state before run", 32'(IDLE), 32'(state));

		for (int p = 0; p < PROGRAM_COUNT; p++) begin
			load_and_start(p);
			wait_for_halt(p);
		end

		$display("TESTS PASSED");
		$finish;
	end

endmodule
